// ==== Bender.yml ====
package:
  name: lsu_subsys

dependencies: {}

sources:
  # Shared types
  - common/lsu_pkg.sv
  # Design
  - lsu/lsu_issue.sv
  - hdl/lsu_data_mem.sv
  - lsu/lsu_load_align.sv
  - hdl/lsu_subsys_top.sv
  # Testbench
  - target: test
    files:
      - test/tb_lsu_subsys.sv

// ==== build.f ====
common/lsu_pkg.sv
lsu/lsu_issue.sv
hdl/lsu_data_mem.sv
lsu/lsu_load_align.sv
hdl/lsu_subsys_top.sv
test/tb_lsu_subsys.sv

// ==== common/lsu_pkg.sv ====
/* Encodings and payload types shared by the load/store path
 * Payload fields are fixed at 64 bits; with XLEN 32 only the low half carries data
 */
package lsu_pkg;

  //////////////////// Opcodes
  // instr[6:2], the low two bits must be 2'b11
  localparam logic [4:0] opc_load_c  = 5'b00000;
  localparam logic [4:0] opc_store_c = 5'b01000;

  //////////////////// funct3
  // Loads
  localparam logic [2:0] f3_lb_c  = 3'b000;
  localparam logic [2:0] f3_lh_c  = 3'b001;
  localparam logic [2:0] f3_lw_c  = 3'b010;
  localparam logic [2:0] f3_ld_c  = 3'b011;  // RV64 only
  localparam logic [2:0] f3_lbu_c = 3'b100;
  localparam logic [2:0] f3_lhu_c = 3'b101;
  localparam logic [2:0] f3_lwu_c = 3'b110;  // RV64 only
  // Stores
  localparam logic [2:0] f3_sb_c  = 3'b000;
  localparam logic [2:0] f3_sh_c  = 3'b001;
  localparam logic [2:0] f3_sw_c  = 3'b010;
  localparam logic [2:0] f3_sd_c  = 3'b011;  // RV64 only

  // Same order as funct3[1:0]
  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_half  = 2'd1,
    size_word  = 2'd2,
    size_dword = 2'd3
  } access_size_e;

  // One queued access
  typedef struct packed {
    logic         we;           // Aligned store only
    access_size_e size;
    logic         is_unsigned;  // LBU/LHU/LWU
    logic         misaligned;
    logic [63:0]  adr;
    logic [63:0]  wdata;        // Already on its byte lanes
  } mem_req_t;

  // Load data or fault back from memory
  typedef struct packed {
    logic [63:0]  rdata;        // Whole memory word
    logic [2:0]   offset;       // Byte within the word
    access_size_e size;
    logic         is_unsigned;
    logic         err;
  } mem_rsp_t;

  // Writeback value
  typedef struct packed {
    logic [63:0] data;
    logic        err;
  } lsu_result_t;

  // Byte lanes touched by an access at offset 0
  function automatic logic [7:0] size_lanes(access_size_e size);
    case (size)
      size_byte: return 8'h01;
      size_half: return 8'h03;
      size_word: return 8'h0f;
      default:   return 8'hff;
    endcase
  endfunction

endpackage

// ==== hdl/lsu_data_mem.sv ====
`timescale 1ns/1ps
/* Request queue in front of a byte-enabled synchronous data memory
 * MEM_WORDS should be a power of two, higher address bits are ignored
 * Head is served only on cycles with bank_gnt high
 */
module lsu_data_mem import lsu_pkg::*; #(
  parameter int XLEN      = 32,
  parameter int CREDITS   = 4,
  parameter int MEM_WORDS = 64
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     req_valid,
  input  mem_req_t req,
  input  logic     bank_gnt,
  output logic     credit_return,
  output logic     rsp_valid,
  output mem_rsp_t rsp
);

  localparam int PW   = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int CW   = $clog2(CREDITS + 1);
  localparam int NB   = XLEN / 8;
  localparam int OFFW = $clog2(NB);
  localparam int AW   = $clog2(MEM_WORDS);

  mem_req_t        queue_q [CREDITS];
  logic [PW-1:0]   wr_ptr_q;
  logic [PW-1:0]   rd_ptr_q;
  logic [CW-1:0]   count_q;
  mem_req_t        head;
  logic            serve;
  logic [OFFW-1:0] head_off;
  logic [AW-1:0]   head_idx;
  logic [NB-1:0]   head_be;
  logic [XLEN-1:0] mem_q [MEM_WORDS];

  // Circular pointer step, CREDITS need not be a power of two
  function automatic logic [PW-1:0] ptr_inc(logic [PW-1:0] ptr);
    return (ptr == PW'(CREDITS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////// Queue
  assign head     = queue_q[rd_ptr_q];
  assign serve    = bank_gnt & (count_q != '0);
  assign head_off = head.adr[OFFW-1:0];
  assign head_idx = head.adr[OFFW +: AW];                      // Word index
  assign head_be  = NB'(size_lanes(head.size) << head_off);

  always_ff @(posedge clk) begin
    if (req_valid) begin
      queue_q[wr_ptr_q] <= req;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      count_q       <= '0;
      credit_return <= 1'b0;
      rsp_valid     <= 1'b0;
    end else begin
      if (req_valid) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (serve) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q       <= count_q + CW'(req_valid) - CW'(serve);
      credit_return <= serve;                // Entry freed
      rsp_valid     <= serve & ~head.we;     // Loads and faults answer
    end
  end

  //////////////////// Array
  always_ff @(posedge clk) begin
    if (serve && head.we) begin
      for (int b = 0; b < NB; b++) begin
        if (head_be[b]) begin
          mem_q[head_idx][8*b +: 8] <= head.wdata[8*b +: 8];
        end
      end
    end
  end

  // Response register, array left alone on a fault
  always_ff @(posedge clk) begin
    if (serve && !head.we) begin
      rsp.rdata       <= head.misaligned ? '0 : 64'(mem_q[head_idx]);
      rsp.offset      <= 3'(head_off);
      rsp.size        <= head.size;
      rsp.is_unsigned <= head.is_unsigned;
      rsp.err         <= head.misaligned;
    end
  end

  // Issue credit count keeps the queue from overflowing
  a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
    req_valid |-> count_q != CW'(CREDITS));

  // Response only after a granted load or fault
  a_rsp_source: assert property (@(posedge clk) disable iff (!rstn)
    rsp_valid |-> $past(serve && (head.misaligned || !head.we)));

endmodule

// ==== hdl/lsu_subsys_top.sv ====
`timescale 1ns/1ps
/* Load/store path top: issue, request queue with memory, load align
 * CREDITS from 2 to 8, XLEN 32 or 64
 */
module lsu_subsys_top import lsu_pkg::*; #(
  parameter int XLEN      = 32,
  parameter int CREDITS   = 4,
  parameter int MEM_WORDS = 64
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            in_valid,
  input  logic [31:0]     in_instr,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,
  input  logic            in_kill,
  input  logic            bank_gnt,   // Shared memory port free
  output logic            lsu_stall,
  output logic            result_valid,
  output lsu_result_t     result
);

  logic     req_valid;
  mem_req_t req;
  logic     credit_return;
  logic     rsp_valid;
  mem_rsp_t rsp;

  //////////////////// Issue
  lsu_issue #(
    .XLEN    (XLEN),
    .CREDITS (CREDITS)
  ) u_issue (
    .clk           (clk),
    .rstn          (rstn),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .op_a          (op_a),
    .op_b          (op_b),
    .in_kill       (in_kill),
    .credit_return (credit_return),
    .lsu_stall     (lsu_stall),
    .req_valid     (req_valid),
    .req           (req)
  );

  //////////////////// Queue and memory
  lsu_data_mem #(
    .XLEN      (XLEN),
    .CREDITS   (CREDITS),
    .MEM_WORDS (MEM_WORDS)
  ) u_data_mem (
    .clk           (clk),
    .rstn          (rstn),
    .req_valid     (req_valid),
    .req           (req),
    .bank_gnt      (bank_gnt),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp           (rsp)
  );

  //////////////////// Writeback
  lsu_load_align #(
    .XLEN (XLEN)
  ) u_load_align (
    .clk          (clk),
    .rstn         (rstn),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// ==== lsu/lsu_issue.sv ====
`timescale 1ns/1ps
/* Decode, address generation and credit counting for loads and stores
 * Driver must hold its inputs while lsu_stall is high
 * LD, LWU and SD decode as non-memory instructions when XLEN is 32
 */
module lsu_issue import lsu_pkg::*; #(
  parameter int XLEN    = 32,
  parameter int CREDITS = 4
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            in_valid,
  input  logic [31:0]     in_instr,
  input  logic [XLEN-1:0] op_a,
  input  logic [XLEN-1:0] op_b,
  input  logic            in_kill,
  input  logic            credit_return,
  output logic            lsu_stall,
  output logic            req_valid,
  output mem_req_t        req
);

  localparam int CW   = $clog2(CREDITS + 1);
  localparam int OFFW = $clog2(XLEN / 8);  // Byte offset bits in a word

  logic [4:0]      opcode;
  logic [2:0]      funct3;
  logic            is_load;
  logic            is_store;
  logic            accept;
  logic            spend;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] adr;
  logic [XLEN-1:0] wdata;
  access_size_e    size;
  logic            misaligned;
  logic [CW-1:0]   cnt_q;  // Free queue entries

  //////////////////// Decode
  assign opcode = in_instr[6:2];
  assign funct3 = in_instr[14:12];

  always_comb begin
    is_load  = 1'b0;
    is_store = 1'b0;
    if (in_instr[1:0] == 2'b11) begin  // No compressed forms here
      if (opcode == opc_load_c) begin
        case (funct3)
          f3_lb_c, f3_lh_c, f3_lw_c, f3_lbu_c, f3_lhu_c: is_load = 1'b1;
          f3_ld_c, f3_lwu_c:                             is_load = (XLEN == 64);
          default:                                       is_load = 1'b0;
        endcase
      end
      if (opcode == opc_store_c) begin
        case (funct3)
          f3_sb_c, f3_sh_c, f3_sw_c: is_store = 1'b1;
          f3_sd_c:                   is_store = (XLEN == 64);
          default:                   is_store = 1'b0;
        endcase
      end
    end
  end

  //////////////////// Address and data
  assign imm_i = {{(XLEN-12){in_instr[31]}}, in_instr[31:20]};
  assign imm_s = {{(XLEN-12){in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
  assign adr   = op_a + (is_store ? imm_s : imm_i);
  assign size  = access_size_e'(funct3[1:0]);
  assign wdata = op_b << {adr[OFFW-1:0], 3'b000};  // Onto the address byte lane

  always_comb begin
    case (size)
      size_byte: misaligned = 1'b0;
      size_half: misaligned = adr[0];
      size_word: misaligned = |adr[1:0];
      default:   misaligned = |adr[2:0];
    endcase
  end

  //////////////////// Credits
  assign lsu_stall = (cnt_q == '0);            // Queue may be full
  assign accept    = in_valid & ~lsu_stall;
  assign spend     = accept & ~in_kill & (is_load | is_store);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt_q     <= CW'(CREDITS);
      req_valid <= 1'b0;
    end else begin
      req_valid <= spend;
      case ({spend, credit_return})
        2'b10:   cnt_q <= cnt_q - 1'b1;
        2'b01:   cnt_q <= cnt_q + 1'b1;
        default: cnt_q <= cnt_q;  // Both or neither
      endcase
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (spend) begin
      req.we          <= is_store & ~misaligned;  // Faulted store never writes
      req.size        <= size;
      req.is_unsigned <= funct3[2];
      req.misaligned  <= misaligned;
      req.adr         <= 64'(adr);
      req.wdata       <= 64'(wdata);
    end
  end

  // Every request was paid for on the previous edge
  a_req_paid: assert property (@(posedge clk) disable iff (!rstn)
    req_valid |-> $past(cnt_q) != '0);

  // Memory never returns more credits than it was given
  a_cnt_bound: assert property (@(posedge clk) disable iff (!rstn)
    cnt_q <= CW'(CREDITS));

endmodule

// ==== lsu/lsu_load_align.sv ====
`timescale 1ns/1ps
/* Load data alignment and extension for writeback
 * Writeback always accepts, so there is no back-pressure
 */
module lsu_load_align import lsu_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic        rsp_valid,
  input  mem_rsp_t    rsp,
  output logic        result_valid,
  output lsu_result_t result
);

  logic [63:0]     shifted;
  logic [63:0]     keep;     // Bytes of the access
  logic            msb;
  logic            fill;
  logic [63:0]     ext;
  logic [XLEN-1:0] data_x;

  // Access bytes down to bit 0
  assign shifted = rsp.rdata >> {rsp.offset, 3'b000};

  always_comb begin
    case (rsp.size)
      size_byte: begin
        keep = 64'h0000_0000_0000_00ff;
        msb  = shifted[7];
      end
      size_half: begin
        keep = 64'h0000_0000_0000_ffff;
        msb  = shifted[15];
      end
      size_word: begin
        keep = 64'h0000_0000_ffff_ffff;
        msb  = shifted[31];
      end
      default: begin
        keep = '1;
        msb  = shifted[63];
      end
    endcase
  end

  assign fill   = msb & ~rsp.is_unsigned;                   // Sign or zero
  assign ext    = (shifted & keep) | ({64{fill}} & ~keep);
  assign data_x = ext[XLEN-1:0];                            // Trim to XLEN

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= rsp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid) begin
      result.data <= rsp.err ? '0 : 64'(data_x);  // Faults return zero
      result.err  <= rsp.err;
    end
  end

endmodule

// ==== test/tb_lsu_subsys.sv ====
`timescale 1ns/1ps
/* Testbench for the load/store path with XLEN 32, 4 credits and 64 words
 * Loads only touch bytes that an earlier row has written since the array has no reset
 */
module tb_lsu_subsys import lsu_pkg::*;;

  localparam int XLEN      = 32;
  localparam int CREDITS   = 4;
  localparam int MEM_WORDS = 64;

  localparam logic [1:0] K_LD  = 2'd0;
  localparam logic [1:0] K_ST  = 2'd1;
  localparam logic [1:0] K_ALU = 2'd2;

  localparam logic [1:0] GNT_RANDOM = 2'd0;
  localparam logic [1:0] GNT_LOW    = 2'd1;
  localparam logic [1:0] GNT_HIGH   = 2'd2;

  // Table row where hold marks a stretch with grants forced low
  typedef struct packed {
    logic [1:0]  kind;
    logic [2:0]  f3;
    logic [31:0] base;
    logic [11:0] off;
    logic [31:0] data;
    logic        kill;
    logic        hold;
  } row_t;

  logic            clk;
  logic            rstn;
  logic            in_valid;
  logic [31:0]     in_instr;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic            in_kill;
  logic            bank_gnt;
  logic            lsu_stall;
  logic            result_valid;
  lsu_result_t     result;

  row_t        rows [$];
  lsu_result_t exp_q [$];          // Expected results in issue order
  logic [7:0]  ref_mem [256];      // Byte image of the 64 words
  logic [1:0]  gnt_mode = GNT_RANDOM;
  logic [31:0] lfsr = 32'h02b0_acc5;
  bit          table_done = 1'b0;
  bit          in_sect = 1'b0;
  int          sect_cnt = 0;       // Memory rows accepted in the stretch
  int          n_results = 0;
  int          n_expected = 0;
  int          errors = 0;

  lsu_subsys_top #(
    .XLEN      (XLEN),
    .CREDITS   (CREDITS),
    .MEM_WORDS (MEM_WORDS)
  ) uut (
    .clk          (clk),
    .rstn         (rstn),
    .in_valid     (in_valid),
    .in_instr     (in_instr),
    .op_a         (op_a),
    .op_b         (op_b),
    .in_kill      (in_kill),
    .bank_gnt     (bank_gnt),
    .lsu_stall    (lsu_stall),
    .result_valid (result_valid),
    .result       (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////// Helpers
  // Taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] make_instr(row_t r);
    case (r.kind)
      K_LD:    return {r.off, 5'd1, r.f3, 5'd2, 7'b0000011};
      K_ST:    return {r.off[11:5], 5'd3, 5'd1, r.f3, r.off[4:0], 7'b0100011};
      default: return {r.off, 5'd1, r.f3, 5'd2, 7'b0010011};  // OP-IMM
    endcase
  endfunction

  // RV32 memory ops only without LD, LWU and SD
  function automatic logic is_mem(row_t r);
    if (r.kind == K_LD) begin
      return !(r.f3[1] && r.f3[0]) && !(r.f3[2] && r.f3[1]);
    end
    if (r.kind == K_ST) begin
      return !r.f3[2] && !(r.f3[1] && r.f3[0]);
    end
    return 1'b0;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic add_row(input logic [1:0] kind, input logic [2:0] f3, input logic [31:0] base,
                         input logic [11:0] off, input logic [31:0] data, input logic kill,
                         input logic hold);
    rows.push_back({kind, f3, base, off, data, kill, hold});
  endtask

  // Reference model for one accepted row
  task automatic apply_row(input row_t r);
    logic [31:0] adr;
    logic [31:0] val;
    int          nb;
    lsu_result_t exp;
    if (r.kill || !is_mem(r)) begin
      return;                                   // Spends no credit and gives no result
    end
    if (in_sect) begin
      sect_cnt++;
    end
    adr = r.base + {{20{r.off[11]}}, r.off};
    nb  = 1 << r.f3[1:0];
    exp = '0;
    if (adr % nb != 0) begin
      exp.err = 1'b1;                           // Fault leaves memory untouched
    end else if (r.kind == K_ST) begin
      for (int b = 0; b < nb; b++) begin
        ref_mem[adr[7:0] + b] = r.data[8*b +: 8];
      end
      return;                                   // Stores answer nothing
    end else begin
      val = '0;
      for (int b = 0; b < nb; b++) begin
        val[8*b +: 8] = ref_mem[adr[7:0] + b];
      end
      if (!r.f3[2] && val[8*nb-1]) begin
        for (int k = 8*nb; k < 32; k++) begin
          val[k] = 1'b1;                        // Sign fill
        end
      end
      exp.data = 64'(val);
    end
    exp_q.push_back(exp);
    n_expected++;
  endtask

  task automatic build_table();
    // Parts of words 0 and 1 at every byte and half offset
    add_row(K_ST, f3_sw_c, 32'h00, 12'h000, 32'h1122_3344, 0, 0);
    add_row(K_ST, f3_sw_c, 32'h04, 12'h000, 32'h5566_7788, 0, 0);
    add_row(K_ST, f3_sb_c, 32'h00, 12'h001, 32'h0000_0081, 0, 0);
    add_row(K_ST, f3_sb_c, 32'h03, 12'h000, 32'h0000_00fe, 0, 0);
    add_row(K_ST, f3_sb_c, 32'h04, 12'hffe, 32'h0000_0007, 0, 0);  // Negative offset
    add_row(K_ST, f3_sb_c, 32'h00, 12'h000, 32'h0000_009c, 0, 0);
    add_row(K_ST, f3_sh_c, 32'h04, 12'h000, 32'h0000_beef, 0, 0);
    add_row(K_ST, f3_sh_c, 32'h04, 12'h002, 32'h0000_8001, 0, 0);
    add_row(K_ST, f3_sw_c, 32'h08, 12'h000, 32'hcafe_f00d, 0, 0);
    add_row(K_LD, f3_lw_c, 32'h00, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lb_c, 32'h00, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lbu_c, 32'h00, 12'h001, 32'h0, 0, 0);
    add_row(K_LD, f3_lb_c, 32'h01, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lb_c, 32'h00, 12'h002, 32'h0, 0, 0);
    add_row(K_LD, f3_lbu_c, 32'h00, 12'h003, 32'h0, 0, 0);
    add_row(K_LD, f3_lh_c, 32'h04, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lhu_c, 32'h04, 12'h002, 32'h0, 0, 0);
    add_row(K_LD, f3_lh_c, 32'h06, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lhu_c, 32'h00, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lh_c, 32'h00, 12'h002, 32'h0, 0, 0);
    // Misaligned loads and stores followed by readback
    add_row(K_LD, f3_lw_c, 32'h00, 12'h002, 32'h0, 0, 0);
    add_row(K_ST, f3_sh_c, 32'h08, 12'h001, 32'h0000_1234, 0, 0);
    add_row(K_LD, f3_lw_c, 32'h08, 12'h000, 32'h0, 0, 0);
    add_row(K_ST, f3_sw_c, 32'h06, 12'h000, 32'h0bad_0bad, 0, 0);
    add_row(K_LD, f3_lw_c, 32'h04, 12'h000, 32'h0, 0, 0);
    // Killed, ALU and RV64-only rows do nothing
    add_row(K_ST, f3_sw_c, 32'h08, 12'h000, 32'h0, 1, 0);
    add_row(K_ALU, 3'b000, 32'h08, 12'h004, 32'h0, 0, 0);
    add_row(K_ST, f3_sd_c, 32'h08, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_ld_c, 32'h08, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lwu_c, 32'h08, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lw_c, 32'h08, 12'h000, 32'h0, 0, 0);
    // Grants held low while a killed row spends no credit
    add_row(K_ST, f3_sw_c, 32'h10, 12'h000, 32'h1357_9bdf, 0, 1);
    add_row(K_LD, f3_lw_c, 32'h10, 12'h000, 32'h0, 0, 1);
    add_row(K_LD, f3_lw_c, 32'h10, 12'h000, 32'h0, 1, 1);
    add_row(K_ST, f3_sb_c, 32'h10, 12'h001, 32'h0000_0042, 0, 1);
    add_row(K_LD, f3_lh_c, 32'h10, 12'h000, 32'h0, 0, 1);
    add_row(K_LD, f3_lw_c, 32'h10, 12'h000, 32'h0, 0, 1);
    add_row(K_LD, f3_lbu_c, 32'h11, 12'h000, 32'h0, 0, 1);
    // Random grants again
    add_row(K_ST, f3_sw_c, 32'h20, 12'h000, 32'h0bad_f00d, 0, 0);
    add_row(K_LD, f3_lw_c, 32'h20, 12'h000, 32'h0, 0, 0);
    add_row(K_ST, f3_sb_c, 32'h20, 12'h003, 32'h0000_0011, 0, 0);
    add_row(K_LD, f3_lw_c, 32'h20, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lhu_c, 32'h22, 12'h000, 32'h0, 0, 0);
    add_row(K_LD, f3_lh_c, 32'h24, 12'hffc, 32'h0, 0, 0);
    add_row(K_ST, f3_sh_c, 32'h28, 12'h002, 32'h0000_c0de, 0, 0);
    add_row(K_LD, f3_lhu_c, 32'h2a, 12'h000, 32'h0, 0, 0);
  endtask

  //////////////////// Grant source
  always @(posedge clk) begin
    case (gnt_mode)
      GNT_LOW:  bank_gnt <= 1'b0;
      GNT_HIGH: bank_gnt <= 1'b1;
      default: begin
        lfsr = lfsr_step(lfsr);
        bank_gnt <= lfsr[0];
      end
    endcase
  end

  //////////////////// Result checker
  always @(negedge clk) begin : result_monitor
    lsu_result_t exp;
    if (rstn && result_valid) begin
      if (exp_q.size() == 0) begin
        $display("Result at %0t with no accepted instruction left to answer", $time);
        $display("Errors found");
        $fatal(1, "Extra result");
      end else begin
        exp = exp_q.pop_front();
        n_results++;
        check_val("result.data", result.data, exp.data);
        check_val("result.err", result.err, exp.err);
      end
    end
  end

  //////////////////// Stimulus
  initial begin : stimulus
    row_t r;
    logic stalled;
    int   drain;
    rstn     = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    op_a     = '0;
    op_b     = '0;
    in_kill  = 1'b0;
    bank_gnt = 1'b0;
    build_table();
    table_done = 1'b1;
    repeat (10) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_val("lsu_stall", lsu_stall, 1'b0);
    check_val("result_valid", result_valid, 1'b0);
    @(posedge clk);
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      if (r.hold && !in_sect) begin
        in_valid <= 1'b0;                       // Drain queue until all credits are back
        gnt_mode <= GNT_HIGH;
        repeat (16) @(posedge clk);
        gnt_mode <= GNT_LOW;
        @(posedge clk);
        in_sect  = 1'b1;
        sect_cnt = 0;
      end else if (!r.hold && in_sect) begin
        in_sect = 1'b0;
        gnt_mode <= GNT_RANDOM;
      end
      in_valid <= 1'b1;
      in_instr <= make_instr(r);
      op_a     <= r.base;
      op_b     <= r.data;
      in_kill  <= r.kill;
      do begin
        @(negedge clk);
        stalled = lsu_stall;
        if (in_sect && gnt_mode == GNT_LOW) begin
          check_val("lsu_stall", lsu_stall, sect_cnt == CREDITS);
          if (stalled) begin
            repeat (6) begin
              @(negedge clk);
              check_val("lsu_stall", lsu_stall, 1'b1);  // Stays full without grants
            end
            gnt_mode <= GNT_RANDOM;
          end
        end
        if (!stalled) begin
          apply_row(r);                         // Taken on the next edge
        end
        @(posedge clk);
      end while (stalled);
    end
    in_valid <= 1'b0;
    in_kill  <= 1'b0;
    gnt_mode <= GNT_RANDOM;
    // Queue drains within a bounded number of cycles
    drain = 0;
    while (exp_q.size() != 0 && drain < CREDITS * 50) begin
      @(posedge clk);
      drain++;
    end
    repeat (20) @(posedge clk);                 // Room for any extra result
    @(negedge clk);
    check_val("result count", n_results, n_expected);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  //////////////////// Watchdog
  initial begin : watchdog
    int limit;
    wait (table_done);
    limit = rows.size() * 40 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles, results still missing", limit);
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule
